//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int ADDR_BITS   = 32;
    localparam int WORD_BITS   = 32;
    localparam int NUM_WAYS    = 2;
    localparam int NUM_SETS    = 64;
    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = 4;     // 16-byte lines
    localparam int INDEX_BITS  = 6;     // 64 sets
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int EXC_BITS    = 7;

    typedef logic [ADDR_BITS-1:0]            addr_t;
    typedef logic [WORD_BITS-1:0]            word_t;
    typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;
    typedef logic [TAG_BITS-1:0]             tag_t;
    typedef logic [INDEX_BITS-1:0]           index_t;
    typedef logic [NUM_WAYS-1:0]             way_vec_t;
    typedef logic [EXC_BITS-1:0]             exc_t;

    // burst length field, beats minus one
    localparam logic [7:0] BURST_LINE = 8'(LINE_WORDS - 1);
    localparam logic [7:0] BURST_WORD = 8'd0;

    localparam exc_t EXC_NONE = 7'd0;
    localparam exc_t EXC_ADEF = 7'd8;   // fetch address error

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        REFILL,
        UNC_REQ,
        UNC_WAIT,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- common/fill_if.sv
`default_nettype none

interface fill_if import icache_pkg::*; ();

    way_vec_t fill_we;      // one bit per way, line written this cycle
    index_t   fill_index;
    tag_t     fill_tag;
    line_t    fill_line;    // assembled by the refill buffer

    modport ctrl (
        output fill_we,
        output fill_index,
        output fill_tag
    );

    modport src (
        output fill_line
    );

    modport array (
        input fill_we,
        input fill_index,
        input fill_tag,
        input fill_line
    );

endinterface

`default_nettype wire

//--- icache/icache_ctrl.sv
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  logic       stage_valid,     // lookup stage holds a live request
    input  logic       cache_hit,
    input  logic       uncache_q,
    input  logic       exc_hit,
    input  addr_t      req_addr,
    input  way_vec_t   hit,
    input  way_vec_t   victim,
    input  logic       r_rdy,
    input  logic       fill_done,
    fill_if.ctrl       fill,
    output logic       req_we,
    output logic       rdata_sel,
    output logic       lru_touch,
    output way_vec_t   touch_way,
    output logic       data_valid_raw,
    output logic       cache_ready,
    output logic       r_req,
    output logic       r_data_ready,
    output logic [7:0] r_length
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    way_vec_t    victim_q;
    logic        lookup_empty;
    logic        lookup_hit;
    logic        lookup_miss;
    logic        refill_end;

    assign lookup_empty = (state == LOOKUP) && !stage_valid;
    assign lookup_hit   = (state == LOOKUP) && stage_valid && !exc_hit && !uncache_q && cache_hit;
    assign lookup_miss  = (state == LOOKUP) && stage_valid && !exc_hit && !uncache_q && !cache_hit;
    assign refill_end   = (state == REFILL) && fill_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            victim_q <= '0;
        end else begin
            state <= state_nxt;
            if (lookup_miss) begin
                victim_q <= victim;     // way to replace for this miss
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_empty || lookup_hit) begin
                    state_nxt = valid ? LOOKUP : IDLE;  // keep pipelining
                end else if (exc_hit) begin
                    state_nxt = RESPOND;
                end else if (uncache_q) begin
                    state_nxt = UNC_REQ;
                end else begin
                    state_nxt = MISS_REQ;
                end
            end
            MISS_REQ: begin
                if (r_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (fill_done) begin
                    state_nxt = IDLE;
                end
            end
            UNC_REQ: begin
                if (r_rdy) begin
                    state_nxt = UNC_WAIT;
                end
            end
            UNC_WAIT: begin
                if (fill_done) begin
                    state_nxt = IDLE;
                end
            end
            RESPOND:  state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    // new requests only while the lookup stage can retire this cycle
    assign cache_ready = (state == IDLE) || lookup_empty || lookup_hit;
    assign req_we      = cache_ready;

    assign data_valid_raw = lookup_hit || (state == RESPOND) || refill_end ||
                            ((state == UNC_WAIT) && fill_done);
    assign rdata_sel      = (state == REFILL) || (state == UNC_WAIT);

    assign lru_touch = lookup_hit || refill_end;
    assign touch_way = refill_end ? victim_q : hit;

    assign r_req        = (state == MISS_REQ) || (state == UNC_REQ);
    assign r_data_ready = (state == REFILL) || (state == UNC_WAIT);
    assign r_length     = (state == MISS_REQ) ? BURST_LINE : BURST_WORD;

    assign fill.fill_we    = refill_end ? victim_q : '0;
    assign fill.fill_index = req_addr[OFFSET_BITS +: INDEX_BITS];
    assign fill.fill_tag   = req_addr[ADDR_BITS-1 -: TAG_BITS];

endmodule

`default_nettype wire

//--- icache/tagv_array.sv
`default_nettype none

module tagv_array import icache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  index_t   rd_index,
    input  tag_t     cmp_tag,      // registered physical tag
    fill_if.array    fill,
    output way_vec_t hit,
    output logic     cache_hit
);

    tag_t                tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
    tag_t                tag_q [NUM_WAYS];
    way_vec_t            valid_q;

    // tag storage and read port
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill.fill_we[w]) begin
                tag_mem[w][fill.fill_index] <= fill.fill_tag;
            end
            tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_bits[w] <= '0;
            end
            valid_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill.fill_we[w]) begin
                    valid_bits[w][fill.fill_index] <= 1'b1;
                end
                valid_q[w] <= valid_bits[w][rd_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
        end
    end

    assign cache_hit = |hit;

endmodule

`default_nettype wire

//--- icache/lru_table.sv
`default_nettype none

module lru_table import icache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     touch,
    input  index_t   touch_index,
    input  index_t   victim_index,
    input  way_vec_t touch_way,
    output way_vec_t victim
);

    // bit set means way 1 is least recently used
    logic [NUM_SETS-1:0] lru_bits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[touch_index] <= (touch_way == 2'b01);  // other way becomes lru
        end
    end

    assign victim = lru_bits[victim_index] ? 2'b10 : 2'b01;

endmodule

`default_nettype wire

//--- icache/data_array.sv
`default_nettype none

module data_array import icache_pkg::*; (
    input  logic       clk,
    input  index_t     rd_index,
    input  logic [1:0] word_sel,
    input  way_vec_t   hit,
    fill_if.array      fill,
    output word_t      hit_word
);

    line_t line_mem [NUM_WAYS][NUM_SETS];
    line_t line_q [NUM_WAYS];
    line_t line_sel;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill.fill_we[w]) begin
                line_mem[w][fill.fill_index] <= fill.fill_line;   // whole line
            end
            line_q[w] <= line_mem[w][rd_index];
        end
    end

    always_comb begin
        case (hit)
            2'b01:   line_sel = line_q[0];
            2'b10:   line_sel = line_q[1];
            default: line_sel = '0;     // miss, word unused
        endcase
    end

    assign hit_word = line_sel[word_sel*WORD_BITS +: WORD_BITS];

endmodule

`default_nettype wire

//--- icache/refill_buffer.sv
`default_nettype none

module refill_buffer import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ret_valid,
    input  logic  ret_last,
    input  word_t r_data_mem,
    fill_if.src   fill,
    output word_t first_word,
    output logic  fill_done
);

    logic [$clog2(LINE_WORDS)-1:0] beat_cnt;
    logic                          done_q;
    line_t                         line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= ret_valid && ret_last;    // one pulse after final beat
            if (ret_valid) begin
                beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // beats land in order of return
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            line_q[beat_cnt*WORD_BITS +: WORD_BITS] <= r_data_mem;
        end
    end

    assign fill.fill_line = line_q;
    assign first_word     = line_q[WORD_BITS-1:0];  // uncached result
    assign fill_done      = done_q;

endmodule

`default_nettype wire

//--- design/icache.sv
`default_nettype none

module icache import icache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  logic       flush,
    input  logic       uncache,
    input  addr_t      pc_in,
    input  addr_t      p_addr,
    output logic       data_valid,
    output word_t      r_data,
    output addr_t      pc_out,
    output exc_t       exception,
    output logic       cache_ready,
    output logic       r_req,
    output logic       r_data_ready,
    output logic [7:0] r_length,
    output addr_t      r_addr,
    input  logic       r_rdy,
    input  logic       ret_valid,
    input  logic       ret_last,
    input  word_t      r_data_mem
);

    addr_t    pc_q;
    addr_t    pa_q;
    logic     uncache_q;
    logic     stage_valid_q;
    logic     stage_live;
    logic     req_we;
    logic     rdata_sel;
    logic     lru_touch;
    logic     cache_hit;
    logic     exc_hit;
    logic     fill_done;
    logic     data_valid_raw;
    way_vec_t hit;
    way_vec_t victim;
    way_vec_t touch_way;
    index_t   rd_index;
    index_t   pa_index;
    word_t    hit_word;
    word_t    first_word;
    word_t    refill_word;

    fill_if fill_bus ();

    // request and physical address registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q          <= '0;
            pa_q          <= '0;
            uncache_q     <= 1'b0;
            stage_valid_q <= 1'b0;
        end else if (req_we) begin
            pc_q          <= pc_in;
            pa_q          <= p_addr;
            uncache_q     <= uncache;
            stage_valid_q <= valid;
        end else if (flush) begin
            stage_valid_q <= 1'b0;  // kill lookup stage
        end
    end

    assign stage_live = stage_valid_q && !flush;
    assign pa_index   = pa_q[OFFSET_BITS +: INDEX_BITS];
    assign rd_index   = req_we ? p_addr[OFFSET_BITS +: INDEX_BITS] : pa_index;
    assign exc_hit    = |pc_q[1:0];

    assign r_addr = uncache_q ? {pa_q[ADDR_BITS-1:2], 2'b00}
                              : {pa_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    assign refill_word = fill_bus.fill_line[pc_q[3:2]*WORD_BITS +: WORD_BITS];

    always_comb begin
        if (exc_hit) begin
            r_data = '0;
        end else if (rdata_sel) begin
            r_data = uncache_q ? first_word : refill_word;
        end else begin
            r_data = hit_word;
        end
    end

    assign pc_out     = pc_q;
    assign exception  = exc_hit ? EXC_ADEF : EXC_NONE;
    assign data_valid = data_valid_raw && stage_live;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid          (valid),
        .stage_valid    (stage_live),
        .cache_hit      (cache_hit),
        .uncache_q      (uncache_q),
        .exc_hit        (exc_hit),
        .req_addr       (pa_q),
        .hit            (hit),
        .victim         (victim),
        .r_rdy          (r_rdy),
        .fill_done      (fill_done),
        .fill           (fill_bus),
        .req_we         (req_we),
        .rdata_sel      (rdata_sel),
        .lru_touch      (lru_touch),
        .touch_way      (touch_way),
        .data_valid_raw (data_valid_raw),
        .cache_ready    (cache_ready),
        .r_req          (r_req),
        .r_data_ready   (r_data_ready),
        .r_length       (r_length)
    );

    tagv_array u_tagv (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index  (rd_index),
        .cmp_tag   (pa_q[ADDR_BITS-1 -: TAG_BITS]),
        .fill      (fill_bus),
        .hit       (hit),
        .cache_hit (cache_hit)
    );

    lru_table u_lru (
        .clk          (clk),
        .rst_n        (rst_n),
        .touch        (lru_touch),
        .touch_index  (pa_index),
        .victim_index (pa_index),
        .touch_way    (touch_way),
        .victim       (victim)
    );

    data_array u_data (
        .clk      (clk),
        .rd_index (rd_index),
        .word_sel (pc_q[3:2]),
        .hit      (hit),
        .fill     (fill_bus),
        .hit_word (hit_word)
    );

    refill_buffer u_refill (
        .clk        (clk),
        .rst_n      (rst_n),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .r_data_mem (r_data_mem),
        .fill       (fill_bus),
        .first_word (first_word),
        .fill_done  (fill_done)
    );

endmodule

`default_nettype wire

//--- bench/icache_assert.sv
`default_nettype none

module icache_assert import icache_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       valid,
    input logic       cache_ready,
    input logic       data_valid,
    input logic       r_req,
    input logic       r_rdy,
    input addr_t      r_addr,
    input logic [7:0] r_length,
    input exc_t       exception,
    input logic       stage_live,
    input logic       cache_hit,
    input logic       uncache_q
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // request held with a fixed address until the memory takes it
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        r_req && !r_rdy |=> r_req && $stable(r_addr) && $stable(r_length))
    else begin
        $error("r_req, r_addr or r_length changed before r_rdy");
        fail_count++;
    end

    no_req_on_exc: assert property (@(posedge clk) disable iff (!rst_n)
        stage_live && (exception == EXC_ADEF) |-> !r_req)
    else begin
        $error("r_req raised while an exception response is pending");
        fail_count++;
    end

    hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (valid && cache_ready) ##1 (stage_live && cache_hit && (exception == EXC_NONE) &&
        !uncache_q) |-> data_valid)
    else begin
        $error("data_valid missing one cycle after an accepted hit");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- bench/icache_checker.sv
`default_nettype none

module icache_checker import icache_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       valid,
    input logic       flush,
    input logic       uncache,
    input addr_t      pc_in,
    input addr_t      p_addr,
    input logic       cache_ready,
    input logic       data_valid,
    input word_t      r_data,
    input addr_t      pc_out,
    input exc_t       exception,
    input logic       r_req,
    input logic       r_rdy,
    input logic       r_data_ready,
    input logic [7:0] r_length,
    input addr_t      r_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        addr_t pc;
        word_t data;
        exc_t  exc;
    } resp_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } mem_req_t;

    resp_t    resp_q [$];
    mem_req_t mem_q [$];
    tag_t     tag_model [NUM_WAYS][NUM_SETS];
    logic     valid_model [NUM_WAYS][NUM_SETS];
    logic     lru_model [NUM_SETS];     // number of the lru way
    logic     stage_full = 1'b0;
    logic     mem_wait = 1'b0;          // between handshake and response
    addr_t    stage_pc;
    addr_t    stage_pa;
    logic     stage_unc;
    resp_t    resp_exp;
    mem_req_t mem_exp;
    int       error_count = 0;
    int       check_count = 0;

    // memory word at a word aligned byte address
    function automatic word_t expected_word(addr_t a);
        return a ^ 32'hA5A50000;
    endfunction

    function automatic int outstanding();
        return resp_q.size() + mem_q.size() + int'(stage_full);
    endfunction

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0d ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // reference model of one request leaving the lookup stage
    task automatic predict(addr_t pc, addr_t pa, logic unc);
        index_t idx;
        tag_t   tag;
        int     way;
        resp_t  r;
        logic   ready_exp;
        idx   = pa[9:4];
        tag   = pa[31:10];
        way   = -1;
        r.pc  = pc;
        r.exc = EXC_NONE;
        if (pc[1:0] != 2'b00) begin
            r.exc     = EXC_ADEF;
            r.data    = '0;
            ready_exp = 1'b0;
        end else if (unc) begin
            r.data    = expected_word({pa[31:2], 2'b00});
            ready_exp = 1'b0;
            mem_q.push_back('{addr: {pa[31:2], 2'b00}, len: 8'd0});
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (valid_model[w][idx] && tag_model[w][idx] == tag) begin
                    way = w;
                end
            end
            ready_exp = (way >= 0);     // only a hit keeps accepting
            if (way < 0) begin
                way = int'(lru_model[idx]);     // evict lru way
                tag_model[way][idx]   = tag;
                valid_model[way][idx] = 1'b1;
                mem_q.push_back('{addr: {pa[31:4], 4'h0}, len: 8'd3});
            end
            lru_model[idx] = (way == 0);
            r.data = expected_word({pa[31:2], 2'b00});
        end
        compare("cache_ready", cache_ready, ready_exp);
        resp_q.push_back(r);
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_model[0][s] = 1'b0;
                valid_model[1][s] = 1'b0;
                lru_model[s]      = 1'b0;
            end
            stage_full = 1'b0;
            mem_wait   = 1'b0;
        end else begin
            compare("r_data_ready", r_data_ready, mem_wait);
            if (stage_full && !flush) begin   // flush kills the lookup stage
                predict(stage_pc, stage_pa, stage_unc);
            end
            stage_full = 1'b0;
            if (r_req && r_rdy) begin
                mem_wait = 1'b1;
                if (mem_q.size() == 0) begin
                    error_count++;
                    $display("unexpected memory request at %0d ns to %h", $time, r_addr);
                end else begin
                    mem_exp = mem_q.pop_front();
                    compare("r_addr", r_addr, mem_exp.addr);
                    compare("r_length", 32'(r_length), 32'(mem_exp.len));
                end
            end
            if (data_valid) begin
                mem_wait = 1'b0;
                if (resp_q.size() == 0) begin
                    error_count++;
                    $display("data_valid at %0d ns with no request outstanding", $time);
                end else begin
                    resp_exp = resp_q.pop_front();
                    if (mem_q.size() != 0) begin
                        error_count++;
                        $display("response at %0d ns came without its memory request", $time);
                        mem_q.delete();
                    end
                    compare("r_data", r_data, resp_exp.data);
                    compare("pc_out", pc_out, resp_exp.pc);
                    compare("exception", 32'(exception), 32'(resp_exp.exc));
                end
            end
            if (valid && cache_ready) begin
                stage_full = 1'b1;
                stage_pc   = pc_in;
                stage_pa   = p_addr;
                stage_unc  = uncache;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_icache.sv
`default_nettype none

module tb_icache import icache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;    // cycles

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_DELAY,
        MEM_BURST
    } mem_state_t;

    logic       clk;
    logic       rst_n;
    logic       valid;
    logic       flush;
    logic       uncache;
    addr_t      pc_in;
    addr_t      p_addr;
    logic       data_valid;
    word_t      r_data;
    addr_t      pc_out;
    exc_t       exception;
    logic       cache_ready;
    logic       r_req;
    logic       r_data_ready;
    logic [7:0] r_length;
    addr_t      r_addr;
    logic       r_rdy;
    logic       ret_valid;
    logic       ret_last;
    word_t      r_data_mem;
    mem_state_t mem_state;
    int         seed = 32'h7326ad74;
    int         delay_cnt;
    int         beat_idx;
    int         beat_total;
    addr_t      burst_addr;
    int         err_before = 0;
    int         test_count = 0;

    icache i_icache (.*);

    icache_checker i_checker (.*);

    bind icache icache_assert i_assert (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .cache_ready (cache_ready),
        .data_valid  (data_valid),
        .r_req       (r_req),
        .r_rdy       (r_rdy),
        .r_addr      (r_addr),
        .r_length    (r_length),
        .exception   (exception),
        .stage_live  (stage_live),
        .cache_hit   (cache_hit),
        .uncache_q   (uncache_q)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic word_t memory_word(addr_t a);
        return a ^ 32'hA5A50000;
    endfunction

    function automatic int total_errors();
        return i_checker.error_count + i_icache.i_assert.fail_count;
    endfunction

    // memory model, random handshake delay and random beat gaps
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_state <= MEM_IDLE;
            r_rdy     <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
        end else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            case (mem_state)
                MEM_IDLE: begin
                    if (r_req) begin
                        delay_cnt <= $unsigned($random(seed)) % 32'd4;
                        mem_state <= MEM_DELAY;
                    end
                end
                MEM_DELAY: begin
                    if (r_rdy && r_req) begin   // handshake edge
                        r_rdy      <= 1'b0;
                        burst_addr <= r_addr;
                        beat_total <= int'(r_length) + 1;
                        beat_idx   <= 0;
                        mem_state  <= MEM_BURST;
                    end else if (delay_cnt == 0) begin
                        r_rdy <= 1'b1;
                    end else begin
                        delay_cnt <= delay_cnt - 1;
                    end
                end
                default: begin
                    if ($random(seed) & 1) begin    // otherwise a gap
                        ret_valid  <= 1'b1;
                        ret_last   <= (beat_idx == beat_total - 1);
                        r_data_mem <= memory_word(burst_addr + addr_t'(4 * beat_idx));
                        beat_idx   <= beat_idx + 1;
                        if (beat_idx == beat_total - 1) begin
                            mem_state <= MEM_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Something failed");
        $finish;
    endtask

    // holds valid until the cache accepts the request
    task automatic fetch(addr_t pc, addr_t pa, logic unc);
        int cycles;
        valid   <= 1'b1;
        pc_in   <= pc;
        p_addr  <= pa;
        uncache <= unc;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!cache_ready && cycles < WAIT_LIMIT);
        valid <= 1'b0;
        if (!cache_ready) begin
            abort_run("timeout while waiting for cache_ready");
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((i_checker.outstanding() != 0 || mem_state != MEM_IDLE) &&
                   cycles < WAIT_LIMIT);
        if (i_checker.outstanding() != 0 || mem_state != MEM_IDLE) begin
            abort_run("timeout while waiting for the outstanding responses");
        end else begin
            repeat (3) @(posedge clk);  // room for stray responses
        end
    endtask

    task automatic finish_test(string name);
        int errs;
        errs = total_errors() - err_before;
        test_count++;
        $display("test %0d, %s: %0d errors", test_count, name, errs);
        err_before = total_errors();
    endtask

    initial begin
        rst_n      = 1'b0;
        valid      = 1'b0;
        flush      = 1'b0;
        uncache    = 1'b0;
        pc_in      = '0;
        p_addr     = '0;
        r_rdy      = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        r_data_mem = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        fetch(32'h0000_1040, 32'h0000_1040, 1'b0);
        drain();
        fetch(32'h0000_1044, 32'h0000_1044, 1'b0);   // same line, hit
        drain();
        finish_test("cold miss then hit");

        for (int i = 0; i < LINE_WORDS; i++) begin
            fetch(32'h0000_1040 + 4 * i, 32'h0000_1040 + 4 * i, 1'b0);
        end
        drain();
        finish_test("back to back hits");

        // three tags in set 8
        fetch(32'h0000_2080, 32'h0000_2080, 1'b0);
        fetch(32'h0000_3084, 32'h0000_3084, 1'b0);
        fetch(32'h0000_2088, 32'h0000_2088, 1'b0);
        fetch(32'h0000_408c, 32'h0000_408c, 1'b0);
        fetch(32'h0000_2080, 32'h0000_2080, 1'b0);
        fetch(32'h0000_3080, 32'h0000_3080, 1'b0);
        fetch(32'h0000_4080, 32'h0000_4080, 1'b0);
        drain();
        finish_test("lru eviction");

        fetch(32'h0000_1048, 32'h0000_1048, 1'b1);
        fetch(32'h0000_1048, 32'h0000_1048, 1'b1);
        fetch(32'h0000_5004, 32'h0000_5004, 1'b1);
        drain();
        finish_test("uncached reads");

        fetch(32'h0000_1042, 32'h0000_1042, 1'b0);
        fetch(32'h0000_6001, 32'h0000_6001, 1'b0);
        fetch(32'h0000_5003, 32'h0000_5003, 1'b1);
        drain();
        finish_test("misaligned pc");

        fetch(32'h0000_7000, 32'h0000_7000, 1'b0);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        drain();
        fetch(32'h0000_7000, 32'h0000_7000, 1'b0);   // never allocated, misses
        fetch(32'h0000_1040, 32'h0000_1040, 1'b0);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        drain();
        fetch(32'h0000_1040, 32'h0000_1040, 1'b0);
        drain();
        finish_test("flush");

        $display("tests %0d, checks %0d, errors %0d", test_count, i_checker.check_count,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/icache_pkg.sv
common/fill_if.sv
icache/icache_ctrl.sv
icache/tagv_array.sv
icache/lru_table.sv
icache/data_array.sv
icache/refill_buffer.sv
design/icache.sv
bench/icache_assert.sv
bench/icache_checker.sv
bench/tb_icache.sv
